/* hdl/parser_params.svh */
`ifndef PARSER_PARAMS_SVH
`define PARSER_PARAMS_SVH

// Protocol identifiers
`define PARSER_ETHER_TYPE_IPV4      16'h0800
`define PARSER_IPV4_PROTOCOL_UDP    8'd17

// IPv4 header without options plus the UDP header
`define PARSER_HEADER_OVERHEAD      16'd28

// Payloads shorter than this are followed by Ethernet pad
`define PARSER_MIN_PAYLOAD          16'd18

// Reflected form of the Ethernet CRC-32
`define PARSER_CRC_POLYNOMIAL       32'hEDB8_8320

`endif

/* hdl/frame_fields_pkg.sv */
package frame_fields_pkg;

////////////////////////////////////////////////////////////
// Header field types
////////////////////////////////////////////////////////////

typedef logic [47:0] mac_address_t;
typedef logic [15:0] ether_type_t;
typedef logic [31:0] ipv4_address_t;
typedef logic [15:0] port_t;
typedef logic [15:0] length_t;

// Flags and offset as they sit in the header word
typedef struct packed {
    logic           reserved;
    logic           dont_fragment;
    logic           more_fragments;
    logic [12:0]    offset;
} ipv4_fragment_fields_t;

typedef union packed {
    logic [15:0]            raw;
    ipv4_fragment_fields_t  fields;
} ipv4_fragment_word_t;

////////////////////////////////////////////////////////////
// Input stream word
////////////////////////////////////////////////////////////

// Start marker rides above the data byte
typedef struct packed {
    logic           start;
    logic [7:0]     data;
} rx_word_t;

endpackage

/* hdl/parser_ctrl_pkg.sv */
package parser_ctrl_pkg;

// Position of a byte inside the frame, in wire order
typedef enum logic [4:0] {
    SEC_MAC_DESTINATION,
    SEC_MAC_SOURCE,
    SEC_ETHER_TYPE,
    SEC_IPV4_VERSION,
    SEC_IPV4_SERVICES,
    SEC_IPV4_TOTAL_LENGTH,
    SEC_IPV4_IDENTIFICATION,
    SEC_IPV4_FRAGMENT,
    SEC_IPV4_TIME_TO_LIVE,
    SEC_IPV4_PROTOCOL,
    SEC_IPV4_HEADER_CHECKSUM,
    SEC_IPV4_SOURCE_ADDRESS,
    SEC_IPV4_DESTINATION_ADDRESS,
    SEC_UDP_HEADER,
    SEC_PAYLOAD,
    SEC_PAD,
    SEC_FCS
} frame_section_t;

typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_HEADER,
    SEQ_PAYLOAD,
    SEQ_PAD,
    SEQ_FCS,
    SEQ_VERDICT,
    SEQ_DROP,
    SEQ_RESTART
} sequencer_state_t;

endpackage

/* hdl/rx_byte_if.sv */
`timescale 1ns/100ps

interface rx_byte_if;

logic [7:0]                         byte_data;
parser_ctrl_pkg::frame_section_t    section;
logic                               byte_strobe;
logic                               frame_start;
logic                               fcs_last;

modport source (
    output byte_data,
    output section,
    output byte_strobe,
    output frame_start,
    output fcs_last
);

modport sink (
    input  byte_data,
    input  section,
    input  byte_strobe,
    input  frame_start,
    input  fcs_last
);

endinterface

/* hdl/header_info_if.sv */
`timescale 1ns/100ps

interface header_info_if;

logic                           is_ipv4;
logic                           is_udp;
logic                           is_fragment;
frame_fields_pkg::length_t      payload_length;

modport source (
    output is_ipv4,
    output is_udp,
    output is_fragment,
    output payload_length
);

modport sink (
    input  is_ipv4,
    input  is_udp,
    input  is_fragment,
    input  payload_length
);

endinterface

/* hdl/frame_sequencer.sv */
`timescale 1ns/100ps
`include "parser_params.svh"

module frame_sequencer (
    input  logic                        clock,
    input  logic                        reset_n,
    input  frame_fields_pkg::rx_word_t  rx_data,
    input  logic                        data_enable,
    output logic                        data_ready,
    rx_byte_if.source                   rx_byte,
    header_info_if.sink                 header_info,
    input  logic                        fcs_ok,
    input  logic                        fcs_done,
    output logic [7:0]                  packet_data,
    output logic                        packet_valid,
    output logic                        good_frame,
    output logic                        bad_frame
);

parser_ctrl_pkg::sequencer_state_t  state;
parser_ctrl_pkg::sequencer_state_t  _state;
parser_ctrl_pkg::frame_section_t    section;
parser_ctrl_pkg::frame_section_t    _section;
logic   [15:0]                      counter;
logic   [15:0]                      _counter;
logic                               in_frame;
logic                               accept;
logic                               last_byte;
logic                               begin_frame;
logic                               early_start;
logic                               short_payload;
logic                               verdict_ready;

// Byte count minus one for each header section
function automatic logic [15:0] section_last(input parser_ctrl_pkg::frame_section_t value);
    case (value)
        parser_ctrl_pkg::SEC_MAC_SOURCE:
            return 16'd5;
        parser_ctrl_pkg::SEC_ETHER_TYPE,
        parser_ctrl_pkg::SEC_IPV4_TOTAL_LENGTH,
        parser_ctrl_pkg::SEC_IPV4_IDENTIFICATION,
        parser_ctrl_pkg::SEC_IPV4_FRAGMENT,
        parser_ctrl_pkg::SEC_IPV4_HEADER_CHECKSUM:
            return 16'd1;
        parser_ctrl_pkg::SEC_IPV4_SOURCE_ADDRESS,
        parser_ctrl_pkg::SEC_IPV4_DESTINATION_ADDRESS,
        parser_ctrl_pkg::SEC_FCS:
            return 16'd3;
        parser_ctrl_pkg::SEC_UDP_HEADER:
            return 16'd7;
        default:
            return 16'd0;
    endcase
endfunction

assign in_frame      = state inside {parser_ctrl_pkg::SEQ_HEADER, parser_ctrl_pkg::SEQ_PAYLOAD,
                                     parser_ctrl_pkg::SEQ_PAD, parser_ctrl_pkg::SEQ_FCS};
assign accept        = data_enable && data_ready;
assign last_byte     = counter == 16'd0;
assign early_start   = in_frame && data_enable && rx_data.start;
assign begin_frame   = accept && !in_frame
                       && (rx_data.start || state == parser_ctrl_pkg::SEQ_RESTART);
assign short_payload = header_info.payload_length < `PARSER_MIN_PAYLOAD;
assign verdict_ready = state == parser_ctrl_pkg::SEQ_VERDICT && fcs_done;

// An early marker is held off for one cycle so the old frame can close
always_comb begin
    if (state == parser_ctrl_pkg::SEQ_VERDICT) begin
        data_ready = 1'b0;
    end
    else if (in_frame) begin
        data_ready = data_enable && !rx_data.start;
    end
    else begin
        data_ready = data_enable;
    end
end

always_comb begin
    _state   = state;
    _section = section;
    _counter = counter;

    if (begin_frame) begin
        _state   = parser_ctrl_pkg::SEQ_HEADER;
        _section = parser_ctrl_pkg::SEC_MAC_DESTINATION;
        _counter = 16'd4;
    end
    else if (early_start) begin
        _state = parser_ctrl_pkg::SEQ_RESTART;
    end
    else if (verdict_ready) begin
        _state = parser_ctrl_pkg::SEQ_IDLE;
    end
    else if (accept && in_frame) begin
        _counter = counter - 16'd1;

        if (last_byte) begin
            _section = parser_ctrl_pkg::frame_section_t'(section + 5'd1);
            _counter = section_last(_section);

            case (section)
                parser_ctrl_pkg::SEC_IPV4_PROTOCOL: begin
                    if (!header_info.is_ipv4) begin
                        _state = parser_ctrl_pkg::SEQ_DROP;
                    end
                end
                parser_ctrl_pkg::SEC_IPV4_HEADER_CHECKSUM: begin
                    if (!header_info.is_udp) begin
                        _state = parser_ctrl_pkg::SEQ_DROP;
                    end
                end
                parser_ctrl_pkg::SEC_IPV4_DESTINATION_ADDRESS: begin
                    if (header_info.is_fragment) begin
                        _state = parser_ctrl_pkg::SEQ_DROP;
                    end
                end
                parser_ctrl_pkg::SEC_UDP_HEADER: begin
                    _state   = parser_ctrl_pkg::SEQ_PAYLOAD;
                    _counter = header_info.payload_length - 16'd1;
                end
                parser_ctrl_pkg::SEC_PAYLOAD: begin
                    if (short_payload) begin
                        _state   = parser_ctrl_pkg::SEQ_PAD;
                        _counter = `PARSER_MIN_PAYLOAD - header_info.payload_length - 16'd1;
                    end
                    else begin
                        _state   = parser_ctrl_pkg::SEQ_FCS;
                        _section = parser_ctrl_pkg::SEC_FCS;
                        _counter = 16'd3;
                    end
                end
                parser_ctrl_pkg::SEC_PAD: begin
                    _state = parser_ctrl_pkg::SEQ_FCS;
                end
                parser_ctrl_pkg::SEC_FCS: begin
                    _state   = parser_ctrl_pkg::SEQ_VERDICT;
                    _section = section;
                end
                default: begin
                end
            endcase
        end
    end
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state               <= parser_ctrl_pkg::SEQ_IDLE;
        section             <= parser_ctrl_pkg::SEC_MAC_DESTINATION;
        counter             <= 16'd0;
        rx_byte.byte_strobe <= 1'b0;
        rx_byte.frame_start <= 1'b0;
        rx_byte.fcs_last    <= 1'b0;
        packet_valid        <= 1'b0;
        good_frame          <= 1'b0;
        bad_frame           <= 1'b0;
    end
    else begin
        state               <= _state;
        section             <= _section;
        counter             <= _counter;
        rx_byte.byte_strobe <= begin_frame || (accept && in_frame);
        rx_byte.frame_start <= begin_frame;
        rx_byte.fcs_last    <= accept && in_frame && last_byte
                               && section == parser_ctrl_pkg::SEC_FCS;
        packet_valid        <= accept && in_frame
                               && (section == parser_ctrl_pkg::SEC_UDP_HEADER
                                   || section == parser_ctrl_pkg::SEC_PAYLOAD);
        good_frame          <= verdict_ready && fcs_ok;
        bad_frame           <= early_start || (verdict_ready && !fcs_ok);
    end
end

// Byte payload, qualified by the strobes above
always_ff @(posedge clock) begin
    rx_byte.byte_data <= rx_data.data;
    rx_byte.section   <= begin_frame ? parser_ctrl_pkg::SEC_MAC_DESTINATION : section;
    packet_data       <= rx_data.data;
end

endmodule

/* hdl/header_fields.sv */
`timescale 1ns/100ps
`include "parser_params.svh"

module header_fields (
    input  logic                                    clock,
    input  logic                                    reset_n,
    rx_byte_if.sink                                 rx_byte,
    header_info_if.source                           header_info,
    output frame_fields_pkg::port_t                 udp_destination,
    output frame_fields_pkg::length_t               ipv4_identification,
    output frame_fields_pkg::ipv4_fragment_word_t   ipv4_fragment
);

frame_fields_pkg::ether_type_t  ether_type;
frame_fields_pkg::length_t      total_length;
logic   [7:0]                   protocol;
logic   [63:0]                  udp_header;

////////////////////////////////////////////////////////////
// Field capture, most significant byte first
////////////////////////////////////////////////////////////

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        ether_type          <= '0;
        total_length        <= '0;
        protocol            <= '0;
        ipv4_identification <= '0;
        ipv4_fragment       <= '0;
    end
    else if (rx_byte.byte_strobe) begin
        case (rx_byte.section)
            parser_ctrl_pkg::SEC_ETHER_TYPE: begin
                ether_type <= {ether_type[7:0], rx_byte.byte_data};
            end
            parser_ctrl_pkg::SEC_IPV4_TOTAL_LENGTH: begin
                total_length <= {total_length[7:0], rx_byte.byte_data};
            end
            parser_ctrl_pkg::SEC_IPV4_IDENTIFICATION: begin
                ipv4_identification <= {ipv4_identification[7:0], rx_byte.byte_data};
            end
            parser_ctrl_pkg::SEC_IPV4_FRAGMENT: begin
                ipv4_fragment.raw <= {ipv4_fragment.raw[7:0], rx_byte.byte_data};
            end
            parser_ctrl_pkg::SEC_IPV4_PROTOCOL: begin
                protocol <= rx_byte.byte_data;
            end
            default: begin
            end
        endcase
    end
end

// Source port, destination port, length, checksum
always_ff @(posedge clock) begin
    if (rx_byte.byte_strobe && rx_byte.section == parser_ctrl_pkg::SEC_UDP_HEADER) begin
        udp_header <= {udp_header[55:0], rx_byte.byte_data};
    end
end

assign udp_destination = udp_header[47:32];

////////////////////////////////////////////////////////////
// Verdicts for the sequencer
////////////////////////////////////////////////////////////

assign header_info.is_ipv4        = ether_type == `PARSER_ETHER_TYPE_IPV4;
assign header_info.is_udp         = protocol == `PARSER_IPV4_PROTOCOL_UDP;
// Any piece but a whole datagram
assign header_info.is_fragment    = ipv4_fragment.fields.more_fragments
                                    || ipv4_fragment.fields.offset != 13'd0;
assign header_info.payload_length = total_length - `PARSER_HEADER_OVERHEAD;

endmodule

/* hdl/fcs_checker.sv */
`timescale 1ns/100ps
`include "parser_params.svh"

module fcs_checker (
    input  logic        clock,
    input  logic        reset_n,
    rx_byte_if.sink     rx_byte,
    output logic        fcs_ok,
    output logic        fcs_done
);

logic   [31:0]  crc;
logic   [31:0]  crc_next;
logic   [31:0]  received_fcs;
logic   [31:0]  fcs_complete;

// One byte through the reflected CRC, LSB first
function automatic logic [31:0] crc_byte(input logic [31:0] seed, input logic [7:0] value);
    logic [31:0] result;
    result = seed ^ {24'd0, value};
    for (int bit_index = 0; bit_index < 8; bit_index++) begin
        if (result[0]) begin
            result = (result >> 1) ^ `PARSER_CRC_POLYNOMIAL;
        end
        else begin
            result = result >> 1;
        end
    end
    return result;
endfunction

assign crc_next     = crc_byte(rx_byte.frame_start ? 32'hFFFF_FFFF : crc, rx_byte.byte_data);
// FCS arrives low byte first
assign fcs_complete = {rx_byte.byte_data, received_fcs[31:8]};

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        crc      <= 32'hFFFF_FFFF;
        fcs_ok   <= 1'b0;
        fcs_done <= 1'b0;
    end
    else begin
        fcs_done <= rx_byte.byte_strobe && rx_byte.fcs_last;

        if (rx_byte.byte_strobe && rx_byte.section != parser_ctrl_pkg::SEC_FCS) begin
            crc <= crc_next;
        end
        if (rx_byte.byte_strobe && rx_byte.fcs_last) begin
            fcs_ok <= fcs_complete == ~crc;
        end
    end
end

always_ff @(posedge clock) begin
    if (rx_byte.byte_strobe && rx_byte.section == parser_ctrl_pkg::SEC_FCS) begin
        received_fcs <= fcs_complete;
    end
end

endmodule

/* hdl/udp_frame_parser.sv */
`timescale 1ns/100ps

module udp_frame_parser (
    input  logic                                    clock,
    input  logic                                    reset_n,
    input  frame_fields_pkg::rx_word_t              rx_data,
    input  logic                                    data_enable,
    output logic                                    data_ready,
    output logic [7:0]                              packet_data,
    output logic                                    packet_valid,
    output logic                                    good_frame,
    output logic                                    bad_frame,
    output frame_fields_pkg::port_t                 udp_destination,
    output frame_fields_pkg::length_t               ipv4_identification,
    output frame_fields_pkg::ipv4_fragment_word_t   ipv4_fragment
);

logic   fcs_ok;
logic   fcs_done;

rx_byte_if      rx_byte ();
header_info_if  header_info ();

frame_sequencer i_frame_sequencer (
    .clock          (clock),
    .reset_n        (reset_n),
    .rx_data        (rx_data),
    .data_enable    (data_enable),
    .data_ready     (data_ready),
    .rx_byte        (rx_byte.source),
    .header_info    (header_info.sink),
    .fcs_ok         (fcs_ok),
    .fcs_done       (fcs_done),
    .packet_data    (packet_data),
    .packet_valid   (packet_valid),
    .good_frame     (good_frame),
    .bad_frame      (bad_frame)
);

header_fields i_header_fields (
    .clock                  (clock),
    .reset_n                (reset_n),
    .rx_byte                (rx_byte.sink),
    .header_info            (header_info.source),
    .udp_destination        (udp_destination),
    .ipv4_identification    (ipv4_identification),
    .ipv4_fragment          (ipv4_fragment)
);

fcs_checker i_fcs_checker (
    .clock      (clock),
    .reset_n    (reset_n),
    .rx_byte    (rx_byte.sink),
    .fcs_ok     (fcs_ok),
    .fcs_done   (fcs_done)
);

endmodule

/* verification/frame_builder.svh */
`ifndef FRAME_BUILDER_SVH
`define FRAME_BUILDER_SVH

////////////////////////////////////////////////////////////
// Reference CRC and frame assembly
////////////////////////////////////////////////////////////

// Reflected Ethernet CRC-32, one data bit at a time
function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] value);
    logic [31:0] next;
    logic        feedback;
    next = crc;
    for (int i = 0; i < 8; i++) begin
        feedback = next[0] ^ value[i];
        next     = next >> 1;
        if (feedback) begin
            next = next ^ 32'hEDB8_8320;
        end
    end
    return next;
endfunction

function automatic logic [31:0] frame_crc();
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (frame_bytes[i]) begin
        crc = crc32_step(crc, frame_bytes[i]);
    end
    return ~crc;
endfunction

// Header fields go out most significant byte first
function automatic void append_field(input logic [31:0] value, input int count);
    for (int i = count - 1; i >= 0; i--) begin
        frame_bytes.push_back(value[8 * i +: 8]);
    end
endfunction

function automatic void fill_random(input int count);
    repeat (count) begin
        frame_bytes.push_back(8'($urandom));
    end
endfunction

task automatic build_frame(input int payload_length, input logic [15:0] ether_type,
                           input logic [7:0] protocol, input logic [15:0] fragment,
                           input bit corrupt_fcs, input bit truncated);
    logic [15:0] identification;
    logic [15:0] destination_port;
    logic [31:0] fcs;
    int          udp_start;
    bit          forwarded;
    identification   = 16'($urandom);
    destination_port = 16'($urandom);
    forwarded        = ether_type == `PARSER_ETHER_TYPE_IPV4
                       && protocol == `PARSER_IPV4_PROTOCOL_UDP
                       && !fragment[13] && fragment[12:0] == 13'd0 && !truncated;
    frame_bytes.delete();
    fill_random(12);
    append_field(ether_type, 2);
    append_field(8'h45, 1);
    append_field(8'h00, 1);
    append_field(payload_length + `PARSER_HEADER_OVERHEAD, 2);
    append_field(identification, 2);
    append_field(fragment, 2);
    append_field(8'd64, 1);
    append_field(protocol, 1);
    // Checksum and both addresses
    fill_random(10);
    udp_start = frame_bytes.size();
    fill_random(2);
    append_field(destination_port, 2);
    append_field(payload_length + 8, 2);
    fill_random(2 + payload_length);
    if (forwarded) begin
        for (int i = udp_start; i < frame_bytes.size(); i++) begin
            expected_bytes.push_back(frame_bytes[i]);
        end
    end
    if (payload_length < `PARSER_MIN_PAYLOAD) begin
        repeat (`PARSER_MIN_PAYLOAD - payload_length) begin
            frame_bytes.push_back(8'h00);
        end
    end
    fcs = frame_crc();
    if (corrupt_fcs) begin
        fcs = fcs ^ (32'd1 << ($urandom % 32));
    end
    // FCS goes out low byte first
    for (int i = 0; i < 4; i++) begin
        frame_bytes.push_back(fcs[8 * i +: 8]);
    end
    if (forwarded || truncated) begin
        expected_verdicts.push_back(forwarded && !corrupt_fcs);
        expected_destinations.push_back(destination_port);
        expected_identifications.push_back(identification);
        expected_fragments.push_back(fragment);
    end
endtask

////////////////////////////////////////////////////////////
// Byte driving
////////////////////////////////////////////////////////////

// Holds the word until the DUT takes it, returns after that edge
task automatic drive_word(input logic start, input logic [7:0] value);
    @(negedge clock);
    rx_data.start = start;
    rx_data.data  = value;
    data_enable   = 1'b1;
    #1;
    while (!data_ready) begin
        @(negedge clock);
        #1;
    end
    @(posedge clock);
endtask

task automatic play_frame(input int count);
    for (int i = 0; i < count; i++) begin
        drive_word(i == 0, frame_bytes[i]);
    end
endtask

task automatic idle_for(input int cycles);
    @(negedge clock);
    data_enable = 1'b0;
    rx_data     = '0;
    repeat (cycles) begin
        @(negedge clock);
    end
endtask

`endif

/* verification/tb_udp_frame_parser.sv */
`timescale 1ns/100ps
`include "parser_params.svh"

module tb_udp_frame_parser;

localparam int CLOCK_PERIOD    = 40;
localparam int MAX_PAYLOAD     = 64;
localparam int GAP_MAX         = 8;
localparam int DRAIN_CYCLES    = 8;
localparam int FRAME_COUNT     = 16;
// Ethernet, IPv4 and UDP headers plus FCS around the payload
localparam int MAX_FRAME_BYTES = 46 + MAX_PAYLOAD;
localparam int TEST_BYTES      = FRAME_COUNT * (MAX_FRAME_BYTES + GAP_MAX + DRAIN_CYCLES) + 16;
localparam int WATCHDOG_TIME   = TEST_BYTES * CLOCK_PERIOD * 4;

logic                                   clock = 1'b0;
logic                                   reset_n;
frame_fields_pkg::rx_word_t             rx_data;
logic                                   data_enable;
logic                                   data_ready;
logic [7:0]                             packet_data;
logic                                   packet_valid;
logic                                   good_frame;
logic                                   bad_frame;
frame_fields_pkg::port_t                udp_destination;
frame_fields_pkg::length_t              ipv4_identification;
frame_fields_pkg::ipv4_fragment_word_t  ipv4_fragment;

logic [7:0]     frame_bytes[$];
logic [7:0]     expected_bytes[$];
bit             expected_verdicts[$];
logic [15:0]    expected_destinations[$];
logic [15:0]    expected_identifications[$];
logic [15:0]    expected_fragments[$];
int             error_count;
int             test_errors_start;
int             test_count;
int             passed_count;

`include "frame_builder.svh"

always #(CLOCK_PERIOD / 2) clock = ~clock;

udp_frame_parser i_udp_frame_parser (
    .clock                  (clock),
    .reset_n                (reset_n),
    .rx_data                (rx_data),
    .data_enable            (data_enable),
    .data_ready             (data_ready),
    .packet_data            (packet_data),
    .packet_valid           (packet_valid),
    .good_frame             (good_frame),
    .bad_frame              (bad_frame),
    .udp_destination        (udp_destination),
    .ipv4_identification    (ipv4_identification),
    .ipv4_fragment          (ipv4_fragment)
);

////////////////////////////////////////////////////////////
// Output checks, sampled mid-cycle
////////////////////////////////////////////////////////////

always @(negedge clock) begin
    if (reset_n && packet_valid) begin
        assert (expected_bytes.size() != 0)
        else begin
            $display("Packet byte %h came out at %0t while none was expected", packet_data, $time);
            error_count++;
        end
        if (expected_bytes.size() != 0) begin
            assert (packet_data == expected_bytes[0])
            else begin
                $display("[FAIL] %0t: packet byte %h, expected %h", $time, packet_data,
                         expected_bytes[0]);
                error_count++;
            end
            void'(expected_bytes.pop_front());
        end
    end
end

always @(negedge clock) begin
    if (reset_n && (good_frame || bad_frame)) begin
        assert (!(good_frame && bad_frame))
        else begin
            $display("[FAIL] %0t: good and bad frame pulses at once", $time);
            error_count++;
        end
        assert (expected_verdicts.size() != 0)
        else begin
            $display("A verdict pulse came at %0t for a frame that should give none", $time);
            error_count++;
        end
        if (expected_verdicts.size() != 0) begin
            assert (good_frame == expected_verdicts[0])
            else begin
                $display("[FAIL] %0t: good_frame %b, expected %b", $time, good_frame,
                         expected_verdicts[0]);
                error_count++;
            end
            if (good_frame && expected_verdicts[0]) begin
                assert (udp_destination == expected_destinations[0])
                else begin
                    $display("[FAIL] %0t: udp_destination %h, expected %h", $time,
                             udp_destination, expected_destinations[0]);
                    error_count++;
                end
                assert (ipv4_identification == expected_identifications[0])
                else begin
                    $display("[FAIL] %0t: ipv4_identification %h, expected %h", $time,
                             ipv4_identification, expected_identifications[0]);
                    error_count++;
                end
                assert (ipv4_fragment.raw == expected_fragments[0])
                else begin
                    $display("[FAIL] %0t: ipv4_fragment %h, expected %h", $time,
                             ipv4_fragment.raw, expected_fragments[0]);
                    error_count++;
                end
            end
            void'(expected_verdicts.pop_front());
            void'(expected_destinations.pop_front());
            void'(expected_identifications.pop_front());
            void'(expected_fragments.pop_front());
        end
    end
end

////////////////////////////////////////////////////////////
// Test flow
////////////////////////////////////////////////////////////

task automatic check_crc_reference();
    frame_bytes.delete();
    for (int i = 0; i < 9; i++) begin
        frame_bytes.push_back(8'h31 + 8'(i));
    end
    assert (frame_crc() == 32'hCBF4_3926)
    else begin
        $display("[FAIL] %0t: reference CRC-32 of the check string is %h", $time, frame_crc());
        error_count++;
    end
endtask

task automatic wait_drained();
    idle_for(0);
    while (expected_bytes.size() != 0 || expected_verdicts.size() != 0) begin
        @(negedge clock);
    end
    repeat (DRAIN_CYCLES) begin
        @(negedge clock);
    end
endtask

task automatic finish_test(input string name);
    test_count++;
    if (error_count == test_errors_start) begin
        passed_count++;
        $display("Test %0d, %s: ok", test_count, name);
    end
    else begin
        $display("Test %0d, %s: %0d errors", test_count, name, error_count - test_errors_start);
    end
    test_errors_start = error_count;
endtask

initial begin
    logic [15:0] ether_type;
    logic [7:0]  protocol;
    logic [15:0] fragment;
    rx_data           = '0;
    data_enable       = 1'b0;
    reset_n           = 1'b0;
    error_count       = 0;
    test_errors_start = 0;
    test_count        = 0;
    passed_count      = 0;
    void'($urandom(36));
    check_crc_reference();
    repeat (5) begin
        @(negedge clock);
    end
    reset_n = 1'b1;

    // Quiet outputs until the source offers data
    repeat (3) begin
        @(negedge clock);
        #1;
        assert (!data_ready && !packet_valid && !good_frame && !bad_frame)
        else begin
            $display("[FAIL] %0t: outputs active after reset with no input", $time);
            error_count++;
        end
    end
    @(negedge clock);
    data_enable = 1'b1;
    #1;
    assert (data_ready)
    else begin
        $display("[FAIL] %0t: data_ready low in idle with data_enable high", $time);
        error_count++;
    end
    idle_for(2);
    finish_test("reset state");

    repeat (3) begin
        build_frame(18 + $urandom % (MAX_PAYLOAD - 17), `PARSER_ETHER_TYPE_IPV4,
                    `PARSER_IPV4_PROTOCOL_UDP, {1'b0, 1'($urandom), 14'd0}, 1'b0, 1'b0);
        play_frame(frame_bytes.size());
        idle_for($urandom % GAP_MAX);
    end
    wait_drained();
    finish_test("full-size UDP frames");

    for (int corrupt = 0; corrupt < 3; corrupt++) begin
        build_frame(corrupt == 2 ? 18 + $urandom % (MAX_PAYLOAD - 17) : 1 + $urandom % 17,
                    `PARSER_ETHER_TYPE_IPV4, `PARSER_IPV4_PROTOCOL_UDP, 16'h4000,
                    corrupt != 0, 1'b0);
        play_frame(frame_bytes.size());
        idle_for($urandom % GAP_MAX);
    end
    wait_drained();
    finish_test("short payload and FCS errors");

    for (int kind = 0; kind < 3; kind++) begin
        ether_type = kind == 0 ? 16'h86DD : `PARSER_ETHER_TYPE_IPV4;
        protocol   = kind == 1 ? 8'd6 : `PARSER_IPV4_PROTOCOL_UDP;
        fragment   = kind == 2 ? {3'b000, 13'(1 + $urandom % 8191)} : 16'h4000;
        build_frame(1 + $urandom % MAX_PAYLOAD, ether_type, protocol, fragment, 1'b0, 1'b0);
        play_frame(frame_bytes.size());
        idle_for(DRAIN_CYCLES);
        build_frame(1 + $urandom % MAX_PAYLOAD, `PARSER_ETHER_TYPE_IPV4,
                    `PARSER_IPV4_PROTOCOL_UDP, 16'h4000, 1'b0, 1'b0);
        play_frame(frame_bytes.size());
        idle_for($urandom % GAP_MAX);
    end
    wait_drained();
    finish_test("dropped frames");

    // Cut off somewhere before the UDP header
    repeat (2) begin
        build_frame(1 + $urandom % MAX_PAYLOAD, `PARSER_ETHER_TYPE_IPV4,
                    `PARSER_IPV4_PROTOCOL_UDP, 16'h4000, 1'b0, 1'b1);
        play_frame(2 + $urandom % 32);
        build_frame(1 + $urandom % MAX_PAYLOAD, `PARSER_ETHER_TYPE_IPV4,
                    `PARSER_IPV4_PROTOCOL_UDP, 16'h4000, 1'b0, 1'b0);
        play_frame(frame_bytes.size());
        idle_for($urandom % GAP_MAX);
    end
    wait_drained();
    finish_test("early start marker");

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d", test_count,
             passed_count, test_count - passed_count, error_count);
    if (error_count == 0) begin
        $display("All tests passed");
    end
    else begin
        $display("Some tests failed");
    end
    $finish;
end

initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("Some tests failed");
    $finish;
end

endmodule

/* project.f */
+incdir+hdl
+incdir+verification
hdl/frame_fields_pkg.sv
hdl/parser_ctrl_pkg.sv
hdl/rx_byte_if.sv
hdl/header_info_if.sv
hdl/frame_sequencer.sv
hdl/header_fields.sv
hdl/fcs_checker.sv
hdl/udp_frame_parser.sv
verification/tb_udp_frame_parser.sv

/* Bender.yml */
package:
  name: udp_frame_parser

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/frame_fields_pkg.sv
      - hdl/parser_ctrl_pkg.sv
      - hdl/rx_byte_if.sv
      - hdl/header_info_if.sv
      - hdl/frame_sequencer.sv
      - hdl/header_fields.sv
      - hdl/fcs_checker.sv
      - hdl/udp_frame_parser.sv
  - target: simulation
    include_dirs:
      - hdl
      - verification
    files:
      - verification/tb_udp_frame_parser.sv
